//--- divider.sv
`timescale 1ns/10ps
`include "mdu_cfg.svh"

module divider (
    input  logic    clk,
    input  logic    rst,
    md_unit_if.unit req,
    input  logic    abort
);
    localparam int W  = `MDU_WIDTH;
    localparam int CW = $clog2(`DIV_ITERS);

    // control
    logic          iter_q;
    logic          fix_q;
    logic          done_q;
    logic [CW-1:0] cnt_q;

    // working registers on magnitudes
    logic [W-1:0]  rem_q;
    logic [W-1:0]  quo_q;
    logic [W-1:0]  dvs_q;
    logic          qneg_q;
    logic          rneg_q;
    logic          dz_q;

    // held result after sign fix
    logic [W-1:0]  res_rem_q;
    logic [W-1:0]  res_quo_q;

    // start-cycle decode
    logic          sign_a;
    logic          sign_b;
    logic [W-1:0]  mag_a;
    logic [W-1:0]  mag_b;

    // one restoring step
    logic [W:0]    shifted;
    logic [W+1:0]  trial;
    logic          fits;

    // signs only count in signed mode
    assign sign_a = req.is_signed & req.a[W-1];
    assign sign_b = req.is_signed & req.b[W-1];
    // most negative value maps to 2**(W-1), which still fits unsigned
    assign mag_a  = sign_a ? -req.a : req.a;
    assign mag_b  = sign_b ? -req.b : req.b;

    // next dividend bit enters the partial remainder
    assign shifted = {rem_q, quo_q[W-1]};
    // extra top bit keeps the borrow visible when shifted overflows W bits
    assign trial   = {1'b0, shifted} - {2'b00, dvs_q};
    assign fits    = !trial[W+1];

    // start loads, then DIV_ITERS steps, then one fix cycle, then done
    always_ff @(posedge clk) begin
        if (rst || abort) begin
            iter_q <= 1'b0;
            fix_q  <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else begin
            done_q <= fix_q;
            fix_q  <= iter_q && (cnt_q == '0);
            if (req.start) begin
                iter_q <= 1'b1;
                cnt_q  <= CW'(`DIV_ITERS - 1);
            end else if (iter_q) begin
                cnt_q <= cnt_q - 1'b1;
                if (cnt_q == '0) begin
                    iter_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req.start) begin
            rem_q  <= '0;
            quo_q  <= mag_a;
            dvs_q  <= mag_b;
            qneg_q <= sign_a ^ sign_b;
            rneg_q <= sign_a;
            dz_q   <= (req.b == '0);
        end else if (iter_q) begin
            // quotient bits shift in as dividend bits shift out
            rem_q <= fits ? trial[W-1:0] : shifted[W-1:0];
            quo_q <= {quo_q[W-2:0], fits};
        end
        if (fix_q) begin
            // zero divisor: every step fits, so rem already equals |a|
            // only the quotient needs forcing
            res_quo_q <= dz_q ? '1 : (qneg_q ? -quo_q : quo_q);
            // remainder follows the dividend sign
            res_rem_q <= rneg_q ? -rem_q : rem_q;
        end
    end

    assign req.done = done_q;

    always_comb begin
        req.result.div.rem  = res_rem_q;
        req.result.div.quot = res_quo_q;
    end

    // controller must not start a second divide mid-loop
    a_no_start_iter: assert property (
        @(posedge clk) disable iff (rst)
        iter_q |-> !req.start
    );

endmodule

//--- hilo_regs.sv
`timescale 1ns/10ps
`include "mdu_cfg.svh"

module hilo_regs (
    input  logic           clk,
    input  logic           rst,
    input  logic           wr_en,
    input  logic           wr_hi_only,
    input  logic           wr_lo_only,
    input  mdu_pkg::hilo_u wr_hilo,
    input  mdu_pkg::word_t mv_data,
    output mdu_pkg::word_t hi,
    output mdu_pkg::word_t lo
);
    localparam int W = `MDU_WIDTH;

    // architectural state, visible after reset as zero
    always_ff @(posedge clk) begin
        if (rst) begin
            hi <= '0;
            lo <= '0;
        end else if (wr_en) begin
            // upper half to hi, lower half to lo, either view
            hi <= wr_hilo.prod[2*W-1:W];
            lo <= wr_hilo.prod[W-1:0];
        end else begin
            // MTHI / MTLO touch one side only
            if (wr_hi_only) begin
                hi <= mv_data;
            end
            if (wr_lo_only) begin
                lo <= mv_data;
            end
        end
    end

    // controller never issues two kinds of write together
    a_one_write: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0({wr_en, wr_hi_only, wr_lo_only})
    );

endmodule

//--- md_unit_if.sv
`timescale 1ns/10ps

interface md_unit_if ();
    import mdu_pkg::*;

    // request side, start is a single-cycle strobe
    logic  start;
    logic  is_signed;
    word_t a;
    word_t b;

    // completion side, done pulses once
    // result stays put until the next start
    logic  done;
    hilo_u result;

    modport ctrl (
        output start, is_signed, a, b,
        input  done, result
    );

    modport unit (
        input  start, is_signed, a, b,
        output done, result
    );

endinterface

//--- mdu.f
+incdir+.
mdu_pkg.sv
md_unit_if.sv
multiplier.sv
divider.sv
mult.sv
hilo_regs.sv
mdu_top.sv
mdu_tb.sv

//--- mdu_cfg.svh
`ifndef MDU_CFG_SVH
`define MDU_CFG_SVH

// datapath width of operands and of each of hi/lo
`define MDU_WIDTH 32

// register levels in the product path after the operand latch
// anything from 2 to 5 keeps the controller timing intact
`define MUL_STAGES 3

// restoring divider produces one quotient bit per cycle
`define DIV_ITERS `MDU_WIDTH

`endif

//--- mdu_golden.txt
# columns: name op a b flush_cycle exp_hi exp_lo
# op a b exp_hi exp_lo in hex, flush_cycle in decimal cycles after issue (0 none)
mult_pos         1 00000007 00000006 0  00000000 0000002a
mult_neg         1 fffffffd 00000005 0  ffffffff fffffff1
mult_negneg      1 fffffff9 fffffff7 0  00000000 0000003f
mult_minmin      1 80000000 80000000 0  40000000 00000000
mult_minmax      1 80000000 7fffffff 0  c0000000 80000000
multu_max        2 ffffffff ffffffff 0  fffffffe 00000001
multu_carry      2 80000000 00000002 0  00000001 00000000
multu_negbits    2 fffffffd 00000005 0  00000004 fffffff1
multu_mid        2 00010001 00010001 0  00000001 00020001
div_pos          3 00000064 00000007 0  00000002 0000000e
div_negdvd       3 ffffff9c 00000007 0  fffffffe fffffff2
div_negdvs       3 00000064 fffffff9 0  00000002 fffffff2
div_negneg       3 ffffff9c fffffff9 0  fffffffe 0000000e
div_ovf          3 80000000 ffffffff 0  00000000 80000000
div_min_by2      3 80000000 00000002 0  00000000 c0000000
divu_big         4 ffffffff 00000010 0  0000000f 0fffffff
divu_third       4 80000000 00000003 0  00000002 2aaaaaaa
div_zero         3 12345678 00000000 0  12345678 ffffffff
div_zero_neg     3 fffffff0 00000000 0  fffffff0 ffffffff
divu_zero        4 00000005 00000000 0  00000005 ffffffff
mthi             5 deadbeef 00000000 0  deadbeef ffffffff
mtlo             6 cafef00d 00000000 0  deadbeef cafef00d
div_flush        3 00000064 00000007 10 deadbeef cafef00d
mult_flush       1 00000007 00000006 2  deadbeef cafef00d
divu_after_flush 4 00000064 00000007 0  00000002 0000000e

//--- mdu_pkg.sv
`include "mdu_cfg.svh"

package mdu_pkg;

    // operation codes seen on the op input
    // NONE means no request this cycle
    typedef enum logic [2:0] {
        NONE  = 3'd0,
        MULT  = 3'd1,
        MULTU = 3'd2,
        DIV   = 3'd3,
        DIVU  = 3'd4,
        MTHI  = 3'd5,
        MTLO  = 3'd6
    } md_op_t;

    // one architectural data word
    typedef logic [`MDU_WIDTH-1:0] word_t;

    // divide view of a unit result
    // remainder sits where hi lives, quotient where lo lives
    typedef struct packed {
        word_t rem;
        word_t quot;
    } div_res_t;

    // one 64-bit unit result, read as a product or as rem/quot
    // both views put hi in the upper half
    typedef union packed {
        logic [2*`MDU_WIDTH-1:0] prod;
        div_res_t                div;
    } hilo_u;

endpackage

//--- mdu_tb.sv
`timescale 1ns/10ps
`include "mdu_cfg.svh"

module mdu_tb;
    import mdu_pkg::*;

    localparam int W          = `MDU_WIDTH;
    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DLY  = 2;
    localparam int N_RANDOM   = 6;

    logic   clk;
    logic   rst;
    logic   flush;
    md_op_t op;
    word_t  a;
    word_t  b;
    word_t  hi;
    word_t  lo;
    logic   busy;

    // raw golden lines, parsed one at a time
    string golden_lines[$];
    logic  golden_ok;

    int   n_tests = 0;
    int   n_pass;
    int   n_fail;
    logic test_bad;
    logic saw_busy;

    mdu_top DUT (
        .clk   (clk),
        .rst   (rst),
        .flush (flush),
        .op    (op),
        .a     (a),
        .b     (b),
        .hi    (hi),
        .lo    (lo),
        .busy  (busy)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // worst case is a full divide per test plus slack
    initial begin
        wait (n_tests > 0);
        repeat (n_tests * (`DIV_ITERS + 10)) @(posedge clk);
        $display("timeout: busy never dropped within %0d cycles", n_tests * (`DIV_ITERS + 10));
        $display("Checks failed");
        $finish;
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            test_bad = 1'b1;
        end
    endtask

    // hi:lo from the arithmetic rules, not from the datapath
    function automatic logic [63:0] expect_hilo(input md_op_t code, input word_t x,
                                                input word_t y);
        logic signed [63:0] sx;
        logic signed [63:0] sy;
        logic signed [63:0] q;
        logic signed [63:0] r;
        logic [63:0]        res;
        sx  = {{W{x[W-1]}}, x};
        sy  = {{W{y[W-1]}}, y};
        res = '0;
        if (code == MULT) begin
            res = sx * sy;
        end else if (code == MULTU) begin
            res = {{W{1'b0}}, x} * {{W{1'b0}}, y};
        end else if (y == '0) begin
            // divide by zero: all ones quotient, dividend left in hi
            res = {x, {W{1'b1}}};
        end else if (code == DIVU) begin
            res = {x % y, x / y};
        end else begin
            // 64-bit math makes min / -1 wrap to min in the low word
            q   = sx / sy;
            r   = sx % sy;
            res = {r[W-1:0], q[W-1:0]};
        end
        return res;
    endfunction

    task automatic load_golden();
        int    fd;
        string line;
        fd        = $fopen("mdu_golden.txt", "r");
        golden_ok = (fd != 0);
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                // skip column notes and blank lines
                if (line.len() > 1 && line.getc(0) != "#") begin
                    golden_lines.push_back(line);
                end
            end
            $fclose(fd);
        end
    endtask

    // issue one op, optionally flush or push a second op while busy
    task automatic run_test(input string name, input md_op_t code, input word_t x,
                            input word_t y, input int flush_at, input logic intrude,
                            input logic [63:0] expected);
        int cyc;
        test_bad = 1'b0;
        saw_busy = 1'b0;
        op       = code;
        a        = x;
        b        = y;
        cyc      = 0;
        do begin
            @(posedge clk);
            #DRIVE_DLY;
            cyc++;
            saw_busy = saw_busy | busy;
            op       = (intrude && cyc == 1) ? DIV : NONE;
            if (intrude && cyc == 1) begin
                a = ~x;
                b = 32'd3;
            end
            // flush is seen at edge N + flush_at
            flush = (flush_at > 0) && (cyc == flush_at);
        end while (busy || flush);
        check_value(name, expected, {hi, lo});
        if (code == MTHI || code == MTLO) begin
            check_value({name, " busy"}, 64'd0, {63'd0, saw_busy});
        end
        tally_test(name);
    endtask

    task automatic tally_test(input string name);
        if (test_bad) begin
            n_fail++;
        end else begin
            n_pass++;
            $display("PASS %s", name);
        end
    endtask

    initial begin
        int              seed_val;
        int              nf;
        logic [8*24-1:0] nm;
        logic [2:0]      o;
        word_t           x;
        word_t           y;
        word_t           h;
        word_t           l;
        int              f;
        md_op_t          code;
        rst      = 1'b1;
        flush    = 1'b0;
        op       = NONE;
        a        = '0;
        b        = '0;
        n_pass   = 0;
        n_fail   = 0;
        seed_val = $urandom(42549);
        load_golden();
        n_tests = golden_lines.size() + N_RANDOM + 2;
        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;

        // registers and busy straight out of reset
        test_bad = 1'b0;
        check_value("reset", 64'd0, {hi, lo});
        check_value("reset busy", 64'd0, {63'd0, busy});
        tally_test("reset");

        if (!golden_ok) begin
            $display("golden file mdu_golden.txt could not be opened");
            n_fail++;
        end
        foreach (golden_lines[i]) begin
            nf = $sscanf(golden_lines[i], "%s %h %h %h %d %h %h", nm, o, x, y, f, h, l);
            if (nf != 7) begin
                $display("golden line %0d could not be parsed", i + 1);
                n_fail++;
            end else begin
                run_test($sformatf("%0s", nm), md_op_t'(o), x, y, f, 1'b0, {h, l});
            end
        end

        // random multiply/divide, divisor shifted down for useful quotients
        for (int i = 0; i < N_RANDOM; i++) begin
            code = md_op_t'($urandom_range(4, 1));
            x    = $urandom;
            y    = $urandom >> $urandom_range(31, 0);
            run_test($sformatf("rand_%0d", i), code, x, y, 0, 1'b0, expect_hilo(code, x, y));
        end

        // the divide pushed in while busy must leave no trace
        x = $urandom;
        y = $urandom;
        run_test("drop_while_busy", MULTU, x, y, 0, 1'b1, expect_hilo(MULTU, x, y));

        $display("%0d tests passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- mdu_top.sv
`timescale 1ns/10ps

module mdu_top (
    input  logic            clk,
    input  logic            rst,
    input  logic            flush,
    input  mdu_pkg::md_op_t op,
    input  mdu_pkg::word_t  a,
    input  mdu_pkg::word_t  b,
    output mdu_pkg::word_t  hi,
    output mdu_pkg::word_t  lo,
    output logic            busy
);
    // controller to unit links
    md_unit_if mul_if ();
    md_unit_if div_if ();

    logic           mul_abort;
    logic           div_abort;
    logic           wr_en;
    logic           wr_hi_only;
    logic           wr_lo_only;
    mdu_pkg::hilo_u wr_hilo;

    mult u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .op         (op),
        .a          (a),
        .b          (b),
        .mul        (mul_if.ctrl),
        .div        (div_if.ctrl),
        .mul_abort  (mul_abort),
        .div_abort  (div_abort),
        .wr_en      (wr_en),
        .wr_hilo    (wr_hilo),
        .wr_hi_only (wr_hi_only),
        .wr_lo_only (wr_lo_only),
        .busy       (busy)
    );

    multiplier u_mul (
        .clk   (clk),
        .rst   (rst),
        .req   (mul_if.unit),
        .abort (mul_abort)
    );

    divider u_div (
        .clk   (clk),
        .rst   (rst),
        .req   (div_if.unit),
        .abort (div_abort)
    );

    // move data comes straight from operand a
    hilo_regs u_hilo (
        .clk        (clk),
        .rst        (rst),
        .wr_en      (wr_en),
        .wr_hi_only (wr_hi_only),
        .wr_lo_only (wr_lo_only),
        .wr_hilo    (wr_hilo),
        .mv_data    (a),
        .hi         (hi),
        .lo         (lo)
    );

endmodule

//--- mult.sv
`timescale 1ns/10ps

module mult (
    input  logic            clk,
    input  logic            rst,
    input  logic            flush,
    input  mdu_pkg::md_op_t op,
    input  mdu_pkg::word_t  a,
    input  mdu_pkg::word_t  b,
    md_unit_if.ctrl         mul,
    md_unit_if.ctrl         div,
    output logic            mul_abort,
    output logic            div_abort,
    output logic            wr_en,
    output mdu_pkg::hilo_u  wr_hilo,
    output logic            wr_hi_only,
    output logic            wr_lo_only,
    output logic            busy
);
    import mdu_pkg::*;

    // two-state FSM
    localparam logic IDLE  = 1'b0;
    localparam logic DOING = 1'b1;

    logic state_q;
    logic state_d;
    // which unit owns the op in flight, 1 for the divider
    logic div_sel_q;
    logic div_sel_d;

    logic accept;
    logic is_mul;
    logic is_div;
    logic unit_done;

    // op only counts while idle, a flush cycle takes nothing
    assign accept = (state_q == IDLE) && !flush;
    assign is_mul = (op == MULT) || (op == MULTU);
    assign is_div = (op == DIV) || (op == DIVU);

    // start strobes last one cycle since the FSM leaves idle at once
    assign mul.start     = accept && is_mul;
    assign mul.is_signed = (op == MULT);
    assign mul.a         = a;
    assign mul.b         = b;

    assign div.start     = accept && is_div;
    assign div.is_signed = (op == DIV);
    assign div.a         = a;
    assign div.b         = b;

    // moves bypass the units and write on the accept edge
    assign wr_hi_only = accept && (op == MTHI);
    assign wr_lo_only = accept && (op == MTLO);

    // completion from the launched unit only
    assign unit_done = div_sel_q ? div.done : mul.done;
    assign wr_en     = (state_q == DOING) && unit_done && !flush;
    assign wr_hilo   = div_sel_q ? div.result : mul.result;

    // flush kills whatever either unit holds
    assign mul_abort = flush;
    assign div_abort = flush;

    assign busy = (state_q == DOING);

    always_comb begin
        state_d   = state_q;
        div_sel_d = div_sel_q;
        case (state_q)
            IDLE: begin
                if (mul.start || div.start) begin
                    state_d   = DOING;
                    div_sel_d = div.start;
                end
            end
            DOING: begin
                if (flush || unit_done) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= IDLE;
            div_sel_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            div_sel_q <= div_sel_d;
        end
    end

    // a done from the idle unit would mean stray pipeline state
    a_mul_done_owned: assert property (
        @(posedge clk) disable iff (rst)
        mul.done |-> busy && !div_sel_q
    );

    a_div_done_owned: assert property (
        @(posedge clk) disable iff (rst)
        div.done |-> busy && div_sel_q
    );

endmodule

//--- multiplier.sv
`timescale 1ns/10ps
`include "mdu_cfg.svh"

module multiplier (
    input  logic    clk,
    input  logic    rst,
    md_unit_if.unit req,
    input  logic    abort
);
    localparam int W = `MDU_WIDTH;
    localparam int S = `MUL_STAGES;

    // operands widened by one bit so one signed multiply covers both modes
    logic signed [W:0]     a_x;
    logic signed [W:0]     b_x;
    logic signed [W:0]     a_q;
    logic signed [W:0]     b_q;
    logic signed [2*W+1:0] prod_full;

    // product pipe, stage 1 holds the raw multiply output
    logic [2*W-1:0]        prod_q [1:S];

    // bit 0 marks the operand latch, bit i marks product stage i
    logic [S:0]            vld_q;

    // unsigned mode pads with zero, signed mode copies the msb
    assign a_x = {req.is_signed & req.a[W-1], req.a};
    assign b_x = {req.is_signed & req.b[W-1], req.b};

    // the 33x33 product, top two bits are only sign copies
    assign prod_full = a_q * b_q;

    // valid bits shift with the data
    // abort empties the whole pipe
    always_ff @(posedge clk) begin
        if (rst || abort) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[S-1:0], req.start};
        end
    end

    // data moves only behind a valid bit so the last stage holds its value
    always_ff @(posedge clk) begin
        if (req.start) begin
            a_q <= a_x;
            b_q <= b_x;
        end
        if (vld_q[0]) begin
            prod_q[1] <= prod_full[2*W-1:0];
        end
        // remaining stages give retiming room for the multiply
        for (int i = 2; i <= S; i++) begin
            if (vld_q[i-1]) begin
                prod_q[i] <= prod_q[i-1];
            end
        end
    end

    assign req.done        = vld_q[S];
    assign req.result.prod = prod_q[S];

    // every done traces back to a start through latch plus all stages
    a_done_has_start: assert property (
        @(posedge clk) disable iff (rst)
        req.done |-> $past(req.start, S + 1)
    );

endmodule
